//--- Makefile
TOP := tb_i2c_target
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a failed check"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "All tests passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- i2c_acq_fifo.sv
////////////////////
// Acquisition FIFO
// Circular buffer with fill level and free space
////////////////////

`timescale 1ns/1ps

module i2c_acq_fifo (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    wr_i,
  input  i2c_acq_pkg::acq_entry_t wdata_i,
  input  logic                    rd_i,
  output i2c_acq_pkg::acq_entry_t rdata_o,
  output i2c_acq_pkg::acq_cnt_t   depth_o,
  output i2c_acq_pkg::acq_cnt_t   free_o
);
  import i2c_acq_pkg::*;

  acq_entry_t mem_q [AcqDepth];
  acq_ptr_t   wr_ptr_q, rd_ptr_q;
  acq_cnt_t   count_q;

  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  // Pointers wrap by overflow, the count tells full from empty
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_i, rd_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Head entry straight from the array
  assign rdata_o = mem_q[rd_ptr_q];
  assign depth_o = count_q;
  assign free_o  = acq_cnt_t'(AcqDepth) - count_q;

  // The writer's space rule must keep it off a full buffer
  NoWriteWhenFull_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_i |-> (count_q != acq_cnt_t'(AcqDepth)))
    else $error("write to full acquisition FIFO");

  NoReadWhenEmpty_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_i |-> (count_q != '0))
    else $error("read from empty acquisition FIFO");

endmodule

//--- i2c_acq_pkg.sv
////////////////////
// Acquisition side of the I2C target
// Entry format codes and the packed FIFO entry
// FIFO depth, pointer and fill-level types
////////////////////

package i2c_acq_pkg;

  // Kind of event that an entry records
  typedef enum logic [2:0] {
    AcqStart    = 3'd0,
    AcqRestart  = 3'd1,
    AcqStop     = 3'd2,
    AcqData     = 3'd3,
    AcqNackStop = 3'd4
  } acq_fmt_e;

  // One FIFO entry, a format code plus the byte that goes with it
  typedef struct packed {
    acq_fmt_e               fmt;
    i2c_bus_pkg::i2c_byte_t data;
  } acq_entry_t;

  // Number of entries the FIFO holds, a power of two
  localparam int unsigned AcqDepth = 8;

  // Pointer width, the pointers wrap at AcqDepth on their own
  localparam int unsigned AcqPtrW = $clog2(AcqDepth);
  typedef logic [AcqPtrW-1:0] acq_ptr_t;

  // Fill level or free space, 0 to AcqDepth
  typedef logic [3:0] acq_cnt_t;

  // Slot that stays free for the closing Stop entry
  localparam int unsigned AcqReserve = 1;

endpackage

//--- i2c_bus_monitor.sv
////////////////////
// I2C bus monitor
// Pin sampling, SCL edge pulses and a filtered
// Start and Stop detector with one shared counter
////////////////////

`timescale 1ns/1ps

module i2c_bus_monitor (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     scl_i,
  input  logic                     sda_i,
  output i2c_bus_pkg::bus_sample_t bus_o
);
  import i2c_bus_pkg::*;

  // Current sample and the one before it, an idle bus reads high
  logic scl_q, sda_q;
  logic scl_p, sda_p;

  // SDA moved while SCL stayed high over both samples
  logic start_trig, stop_trig;

  // A condition waits here until SCL has been high long enough
  logic      pend_start_q, pend_stop_q;
  hold_cnt_t ctrl_cnt_q;
  logic      hold_done;

  // Confirmed conditions, one cycle each
  logic start_q, stop_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_q <= 1'b1;
      sda_q <= 1'b1;
      scl_p <= 1'b1;
      sda_p <= 1'b1;
    end else begin
      scl_q <= scl_i;
      sda_q <= sda_i;
      scl_p <= scl_q;
      sda_p <= sda_q;
    end
  end

  // A falling SDA under high SCL is a Start, a rising one is a Stop
  assign start_trig = scl_q && scl_p && sda_p && !sda_q;
  assign stop_trig  = scl_q && scl_p && !sda_p && sda_q;

  // The pending condition is accepted once the counter reaches the hold time
  assign hold_done = (pend_start_q || pend_stop_q) && scl_q &&
                     (ctrl_cnt_q == hold_cnt_t'(CtrlHoldCycles));

  ////////////////////
  // Start/Stop filter
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_start_q <= 1'b0;
      pend_stop_q  <= 1'b0;
      ctrl_cnt_q   <= '0;
      start_q      <= 1'b0;
      stop_q       <= 1'b0;
    end else begin
      start_q <= hold_done && pend_start_q;
      stop_q  <= hold_done && pend_stop_q;
      if (start_trig) begin
        // A new edge restarts the count and replaces the older condition
        pend_start_q <= 1'b1;
        pend_stop_q  <= 1'b0;
        ctrl_cnt_q   <= hold_cnt_t'(1);
      end else if (stop_trig) begin
        pend_start_q <= 1'b0;
        pend_stop_q  <= 1'b1;
        ctrl_cnt_q   <= hold_cnt_t'(1);
      end else if (hold_done || !scl_q) begin
        // Accepted, or SCL fell too early and this was a data edge
        pend_start_q <= 1'b0;
        pend_stop_q  <= 1'b0;
      end else if (pend_start_q || pend_stop_q) begin
        ctrl_cnt_q <= ctrl_cnt_q + 1'b1;
      end
    end
  end

  assign bus_o.scl       = scl_q;
  assign bus_o.sda       = sda_q;
  assign bus_o.scl_rise  = scl_q && !scl_p;
  assign bus_o.scl_fall  = !scl_q && scl_p;
  assign bus_o.start_det = start_q;
  assign bus_o.stop_det  = stop_q;

  // The FSM relies on never seeing both conditions in one cycle
  StartStopExclusive_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(bus_o.start_det && bus_o.stop_det))
    else $error("start_det and stop_det asserted together");

endmodule

//--- i2c_bus_pkg.sv
////////////////////
// Bus-side types for the I2C target
// Byte, address, bit index and hold counter widths
// Fixed SDA hold and Start/Stop filter timing
// Sampled bus record from the monitor to the FSM
////////////////////

package i2c_bus_pkg;

  // One byte as it travels on SDA
  typedef logic [7:0] i2c_byte_t;

  // A 7-bit target address, also used for its mask
  typedef logic [6:0] i2c_addr_t;

  // Bit slot within a byte, 0 to 7 for data and 8 for the ACK slot
  typedef logic [3:0] bit_idx_t;

  // Counts clk_i cycles for SDA hold and for the Start/Stop filter
  typedef logic [7:0] hold_cnt_t;

  // Cycles SDA is held after the SCL fall before the target moves it
  localparam int unsigned ThdDatCycles = 4;

  // Cycles SCL must stay high after an SDA edge to confirm Start or Stop
  localparam int unsigned CtrlHoldCycles = 5;

  // Slot index of the ACK or NACK bit
  localparam bit_idx_t AckBitIdx = 4'd8;

  // Levels and one-cycle event pulses seen on the bus
  typedef struct packed {
    logic scl;
    logic sda;
    logic scl_rise;
    logic scl_fall;
    logic start_det;
    logic stop_det;
  } bus_sample_t;

endpackage

//--- i2c_target.sv
////////////////////
// I2C target top level
// Bus monitor, state machine and acquisition FIFO
////////////////////

`timescale 1ns/1ps

module i2c_target (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    scl_i,
  input  logic                    sda_i,
  input  i2c_bus_pkg::i2c_addr_t  addr0_i,
  input  i2c_bus_pkg::i2c_addr_t  mask0_i,
  input  i2c_bus_pkg::i2c_addr_t  addr1_i,
  input  i2c_bus_pkg::i2c_addr_t  mask1_i,
  input  logic                    tx_valid_i,
  input  i2c_bus_pkg::i2c_byte_t  tx_data_i,
  input  logic                    acq_rd_i,
  output logic                    sda_o,
  output logic                    tx_pop_o,
  output i2c_acq_pkg::acq_entry_t acq_entry_o,
  output i2c_acq_pkg::acq_cnt_t   acq_depth_o,
  output logic                    target_idle_o,
  output logic                    event_cmd_complete_o,
  output logic                    event_target_nack_o
);
  import i2c_bus_pkg::*;
  import i2c_acq_pkg::*;

  // Registered bus view, one cycle behind the pins
  bus_sample_t bus;

  // Entry write path and the space that gates it
  logic       acq_wr;
  acq_entry_t acq_wdata;
  acq_cnt_t   acq_free;

  i2c_bus_monitor u_monitor (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .scl_i  (scl_i),
    .sda_i  (sda_i),
    .bus_o  (bus)
  );

  i2c_target_fsm u_fsm (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .bus_i                (bus),
    .addr0_i              (addr0_i),
    .mask0_i              (mask0_i),
    .addr1_i              (addr1_i),
    .mask1_i              (mask1_i),
    .tx_valid_i           (tx_valid_i),
    .tx_data_i            (tx_data_i),
    .acq_free_i           (acq_free),
    .sda_o                (sda_o),
    .tx_pop_o             (tx_pop_o),
    .acq_wr_o             (acq_wr),
    .acq_wdata_o          (acq_wdata),
    .target_idle_o        (target_idle_o),
    .event_cmd_complete_o (event_cmd_complete_o),
    .event_target_nack_o  (event_target_nack_o)
  );

  i2c_acq_fifo u_acq_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wr_i    (acq_wr),
    .wdata_i (acq_wdata),
    .rd_i    (acq_rd_i),
    .rdata_o (acq_entry_o),
    .depth_o (acq_depth_o),
    .free_o  (acq_free)
  );

endmodule

//--- i2c_target_fsm.sv
////////////////////
// I2C target state machine
// Bit counter, receive and transmit shift registers,
// address match, ACK decision, SDA drive with hold delay
// and acquisition entry writes
////////////////////

`timescale 1ns/1ps

module i2c_target_fsm (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  i2c_bus_pkg::bus_sample_t bus_i,
  input  i2c_bus_pkg::i2c_addr_t   addr0_i,
  input  i2c_bus_pkg::i2c_addr_t   mask0_i,
  input  i2c_bus_pkg::i2c_addr_t   addr1_i,
  input  i2c_bus_pkg::i2c_addr_t   mask1_i,
  input  logic                     tx_valid_i,
  input  i2c_bus_pkg::i2c_byte_t   tx_data_i,
  input  i2c_acq_pkg::acq_cnt_t    acq_free_i,
  output logic                     sda_o,
  output logic                     tx_pop_o,
  output logic                     acq_wr_o,
  output i2c_acq_pkg::acq_entry_t  acq_wdata_o,
  output logic                     target_idle_o,
  output logic                     event_cmd_complete_o,
  output logic                     event_target_nack_o
);
  import i2c_bus_pkg::*;
  import i2c_acq_pkg::*;

  typedef enum logic [2:0] {
    Idle,
    AddrRead,
    AddrAck,
    TxBit,
    TxAck,
    RxByte,
    RxAck,
    WaitForStop
  } state_e;

  state_e    state_q, state_d;
  bit_idx_t  bit_idx_q;
  logic      bit_valid_q;
  i2c_byte_t rx_shift_q;
  i2c_byte_t tx_shift_q;
  logic      tx_used_q;
  logic      tx_load;
  logic      host_ack_q;
  hold_cnt_t hold_cnt_q;
  logic      hold_done;
  logic      sda_q, sda_next;

  // Transaction flags
  logic restart_q, restart_d;
  logic for_us_q, for_us_d;
  logic nack_q, nack_d;
  logic rw_q, rw_d;

  logic ack_slot;
  logic addr_match;
  logic space_ok;

  assign ack_slot = (bit_idx_q == AckBitIdx);

  // Either masked address may claim the transfer
  assign addr_match = ((rx_shift_q[7:1] & mask0_i) == addr0_i) ||
                      ((rx_shift_q[7:1] & mask1_i) == addr1_i);

  // Accepting a byte must still leave room for the Stop entry
  assign space_ok = (acq_free_i > acq_cnt_t'(AcqReserve));

  ////////////////////
  // Bit tracking
  ////////////////////

  // The first SCL fall after a Start closes the Start itself and is not a bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_idx_q   <= '0;
      bit_valid_q <= 1'b0;
    end else if (bus_i.start_det) begin
      bit_idx_q   <= '0;
      bit_valid_q <= 1'b0;
    end else if (bus_i.scl_fall) begin
      bit_valid_q <= 1'b1;
      if (bit_valid_q) begin
        bit_idx_q <= ack_slot ? bit_idx_t'(0) : bit_idx_q + 1'b1;
      end
    end
  end

  // Data bits enter MSB first on each SCL rise outside the ACK slot
  always_ff @(posedge clk_i) begin
    if (bus_i.scl_rise && !ack_slot) begin
      rx_shift_q <= {rx_shift_q[6:0], bus_i.sda};
    end
  end

  // The host pulls SDA low in the ACK slot to ask for another byte
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      host_ack_q <= 1'b0;
    end else if (bus_i.scl_rise && ack_slot) begin
      host_ack_q <= !bus_i.sda;
    end
  end

  // Read data shifts out MSB first, an empty source sends all ones
  always_ff @(posedge clk_i) begin
    if (tx_load) begin
      tx_shift_q <= tx_valid_i ? tx_data_i : 8'hFF;
    end else if (hold_done && (state_q == TxBit)) begin
      tx_shift_q <= {tx_shift_q[6:0], 1'b1};
    end
  end

  ////////////////////
  // SDA drive
  ////////////////////

  // Every SCL fall starts the hold delay, SDA may move when it expires
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_cnt_q <= '0;
    end else if (bus_i.scl_fall) begin
      hold_cnt_q <= hold_cnt_t'(ThdDatCycles);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  assign hold_done = (hold_cnt_q == hold_cnt_t'(1));

  // Low for an ACK, the current bit while sending, released otherwise
  always_comb begin
    unique case (state_q)
      AddrAck, RxAck: sda_next = !ack_slot;
      TxBit:          sda_next = tx_shift_q[7];
      default:        sda_next = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sda_q <= 1'b1;
    end else if (bus_i.stop_det) begin
      sda_q <= 1'b1;
    end else if (hold_done) begin
      sda_q <= sda_next;
    end
  end

  assign sda_o = sda_q;

  ////////////////////
  // State machine
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= Idle;
      restart_q <= 1'b0;
      for_us_q  <= 1'b0;
      nack_q    <= 1'b0;
      rw_q      <= 1'b0;
      tx_used_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      restart_q <= restart_d;
      for_us_q  <= for_us_d;
      nack_q    <= nack_d;
      rw_q      <= rw_d;
      if (tx_load) begin
        tx_used_q <= tx_valid_i;
      end
    end
  end

  always_comb begin
    state_d              = state_q;
    restart_d            = restart_q;
    for_us_d             = for_us_q;
    nack_d               = nack_q;
    rw_d                 = rw_q;
    tx_load              = 1'b0;
    tx_pop_o             = 1'b0;
    acq_wr_o             = 1'b0;
    acq_wdata_o          = '{fmt: AcqData, data: '0};
    event_cmd_complete_o = 1'b0;
    event_target_nack_o  = 1'b0;

    unique case (state_q)
      Idle: begin
        restart_d = 1'b0;
        for_us_d  = 1'b0;
        nack_d    = 1'b0;
      end
      // The address byte is complete in the first cycle of the ACK slot
      AddrRead: begin
        if (ack_slot) begin
          if (!addr_match) begin
            state_d = WaitForStop;
          end else if (!space_ok) begin
            // Ours, but no room, so NACK and keep no record
            event_target_nack_o = 1'b1;
            state_d             = WaitForStop;
          end else begin
            acq_wr_o         = 1'b1;
            acq_wdata_o.fmt  = restart_q ? AcqRestart : AcqStart;
            acq_wdata_o.data = rx_shift_q;
            for_us_d         = 1'b1;
            rw_d             = rx_shift_q[0];
            state_d          = AddrAck;
          end
        end
      end
      // Leave once the ACK slot has ended
      AddrAck: begin
        if (bit_idx_q == '0) begin
          if (rw_q) begin
            tx_load = 1'b1;
            state_d = TxBit;
          end else begin
            state_d = RxByte;
          end
        end
      end
      TxBit: begin
        if (ack_slot) begin
          tx_pop_o = tx_used_q;
          state_d  = TxAck;
        end
      end
      // A host NACK ends the read
      TxAck: begin
        if (bit_idx_q == '0) begin
          if (host_ack_q) begin
            tx_load = 1'b1;
            state_d = TxBit;
          end else begin
            state_d = WaitForStop;
          end
        end
      end
      RxByte: begin
        if (ack_slot) begin
          if (space_ok) begin
            acq_wr_o         = 1'b1;
            acq_wdata_o.data = rx_shift_q;
            state_d          = RxAck;
          end else begin
            nack_d              = 1'b1;
            event_target_nack_o = 1'b1;
            state_d             = WaitForStop;
          end
        end
      end
      RxAck: begin
        if (bit_idx_q == '0) begin
          state_d = RxByte;
        end
      end
      WaitForStop: begin
        state_d = WaitForStop;
      end
      default: begin
        state_d = Idle;
      end
    endcase

    // Bus conditions take over from any state
    if (bus_i.stop_det) begin
      state_d              = Idle;
      event_cmd_complete_o = for_us_q;
      acq_wr_o             = for_us_q;
      acq_wdata_o          = '{fmt: nack_q ? AcqNackStop : AcqStop, data: '0};
    end else if (bus_i.start_det) begin
      state_d   = AddrRead;
      restart_d = (state_q != Idle);
    end
  end

  assign target_idle_o = (state_q == Idle);

  // The hold delay keeps every SDA change inside the SCL low phase
  SdaStableSclHigh_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bus_i.scl && $past(bus_i.scl) && (state_q != Idle)) |-> $stable(sda_o))
    else $error("sda_o changed while SCL was high");

endmodule

//--- tb.f
+incdir+.
i2c_bus_pkg.sv
i2c_acq_pkg.sv
i2c_bus_monitor.sv
i2c_target_fsm.sv
i2c_acq_fifo.sv
i2c_target.sv
tb_clock.sv
tb_i2c_target.sv

//--- tb_clock.sv
////////////////////
// Testbench clock and reset generator
// 20 ns clock, reset low for 5 cycles
////////////////////

`timescale 1ns/1ps

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  localparam int HalfPeriodNs = 10;
  localparam int ResetCycles  = 5;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriodNs) clk_o = ~clk_o;
  end

  // Reset is released just after a rising edge, like the other stimulus
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #2;
    rst_no = 1'b1;
  end

endmodule

//--- tb_i2c_host.svh
////////////////////
// Host bus model for the I2C target testbench
// Start, restart, Stop, byte write and byte read
// Compare tasks for entries, bytes, bits and counts
////////////////////

`ifndef TB_I2C_HOST_SVH
`define TB_I2C_HOST_SVH

// Advance n clock cycles and land 2 ns past the rising edge
task automatic wait_cycles(input int n);
  repeat (n) @(posedge clk);
  #2;
endtask

// One bit slot that starts and ends with SCL just pulled low
// SDA moves in the middle of the low phase and is sampled in the middle of the high phase
task automatic clock_bit(input logic bit_val, output logic sampled);
  wait_cycles(QuarterCycles);
  sda_host = bit_val;
  wait_cycles(QuarterCycles);
  scl = 1'b1;
  wait_cycles(QuarterCycles);
  sampled = sda_bus;
  wait_cycles(QuarterCycles);
  scl = 1'b0;
endtask

// Start from a free bus where SDA falls while SCL stays high
task automatic bus_start();
  sda_host = 1'b0;
  wait_cycles(2 * QuarterCycles);
  scl = 1'b0;
endtask

// Repeated Start entered with SCL low after an ACK slot
task automatic bus_restart();
  wait_cycles(QuarterCycles);
  sda_host = 1'b1;
  wait_cycles(QuarterCycles);
  scl = 1'b1;
  wait_cycles(2 * QuarterCycles);
  sda_host = 1'b0;
  wait_cycles(2 * QuarterCycles);
  scl = 1'b0;
endtask

// Stop followed by a wait for the target to report idle
task automatic bus_stop();
  int waited;
  waited = 0;
  wait_cycles(QuarterCycles);
  sda_host = 1'b0;
  wait_cycles(QuarterCycles);
  scl = 1'b1;
  wait_cycles(2 * QuarterCycles);
  sda_host = 1'b1;
  while (!target_idle && waited < IdleTimeout) begin
    wait_cycles(1);
    waited++;
  end
  if (!target_idle) begin
    $display("Timed out waiting for the target to go idle after a Stop");
    errors++;
  end
  // Bus free time before the next Start
  wait_cycles(2 * QuarterCycles);
endtask

// Eight data bits MSB first and then the ACK slot with SDA released
task automatic write_byte(input i2c_byte_t data, output logic ack);
  logic sampled;
  for (int i = 7; i >= 0; i--) begin
    clock_bit(data[i], sampled);
  end
  clock_bit(1'b1, sampled);
  ack = !sampled;
endtask

// Eight bits from the target and then the host ACK (low) or NACK (high)
task automatic read_byte(input logic ack, output i2c_byte_t data);
  logic sampled;
  for (int i = 7; i >= 0; i--) begin
    clock_bit(1'b1, sampled);
    data[i] = sampled;
  end
  clock_bit(!ack, sampled);
endtask

task automatic compare_entry(input acq_entry_t got, input acq_entry_t exp, input string what);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("ERR %0t: %s got fmt %0d data %02h, expected fmt %0d data %02h",
             $time, what, got.fmt, got.data, exp.fmt, exp.data);
  end
endtask

task automatic compare_byte(input i2c_byte_t got, input i2c_byte_t exp, input string what);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("ERR %0t: %s got %02h, expected %02h", $time, what, got, exp);
  end
endtask

task automatic compare_bit(input logic got, input logic exp, input string what);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("ERR %0t: %s got %b, expected %b", $time, what, got, exp);
  end
endtask

task automatic compare_count(input acq_cnt_t got, input acq_cnt_t exp, input string what);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("ERR %0t: %s got %0d, expected %0d", $time, what, got, exp);
  end
endtask

`endif

//--- tb_i2c_target.sv
////////////////////
// I2C target testbench
// DUT with a wired-AND SDA line, transmit source,
// event counters and the directed tests
////////////////////

`timescale 1ns/1ps

module tb_i2c_target;
  import i2c_bus_pkg::*;
  import i2c_acq_pkg::*;

  // Two address and mask pairs, the second one covers 0x10 to 0x1F
  localparam i2c_addr_t Addr0 = 7'h42;
  localparam i2c_addr_t Mask0 = 7'h7F;
  localparam i2c_addr_t Addr1 = 7'h10;
  localparam i2c_addr_t Mask1 = 7'h70;

  // One address reached only through the second mask, one reached by neither
  localparam i2c_addr_t AddrMask1Hit = 7'h1A;
  localparam i2c_addr_t AddrForeign  = 7'h33;

  // A quarter of one SCL period, so each SCL phase lasts 12 cycles
  localparam int QuarterCycles = 6;
  localparam int unsigned RandSeed = 67099;
  localparam int ResetTimeout = 20;
  localparam int IdleTimeout  = 100;
  localparam int EntryTimeout = 100;
  localparam int WatchdogNs   = 2_000_000;

  logic       clk;
  logic       rst_n;
  logic       scl;
  logic       sda_host;
  logic       sda_dut;
  logic       sda_bus;
  logic       tx_valid = 1'b0;
  i2c_byte_t  tx_data = 8'h00;
  logic       acq_rd;
  logic       tx_pop;
  acq_entry_t acq_entry;
  acq_cnt_t   acq_depth;
  logic       target_idle;
  logic       cmd_complete;
  logic       target_nack;

  i2c_byte_t tx_queue [$];
  int        errors = 0;
  int        checks = 0;
  int        pop_count = 0;
  int        complete_count = 0;
  int        nack_count = 0;

  // Open-drain line, low when either side pulls it low
  assign sda_bus = sda_host & sda_dut;

  tb_clock clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  i2c_target i2c_target_inst (
    .clk_i                (clk),
    .rst_ni               (rst_n),
    .scl_i                (scl),
    .sda_i                (sda_bus),
    .addr0_i              (Addr0),
    .mask0_i              (Mask0),
    .addr1_i              (Addr1),
    .mask1_i              (Mask1),
    .tx_valid_i           (tx_valid),
    .tx_data_i            (tx_data),
    .acq_rd_i             (acq_rd),
    .sda_o                (sda_dut),
    .tx_pop_o             (tx_pop),
    .acq_entry_o          (acq_entry),
    .acq_depth_o          (acq_depth),
    .target_idle_o        (target_idle),
    .event_cmd_complete_o (cmd_complete),
    .event_target_nack_o  (target_nack)
  );

  `include "tb_i2c_host.svh"

  // Transmit source shows the queue head and drops it on each pop
  always @(posedge clk) begin
    #2;
    if (tx_pop) begin
      pop_count++;
      if (tx_queue.size() > 0) begin
        void'(tx_queue.pop_front());
      end
    end
    if (cmd_complete) begin
      complete_count++;
    end
    if (target_nack) begin
      nack_count++;
    end
    tx_valid = (tx_queue.size() > 0);
    tx_data  = (tx_queue.size() > 0) ? tx_queue[0] : 8'h00;
  end

  function automatic i2c_byte_t address_byte(input i2c_addr_t addr, input logic rd);
    return {addr, rd};
  endfunction

  function automatic acq_entry_t make_entry(input acq_fmt_e fmt, input i2c_byte_t data);
    return '{fmt: fmt, data: data};
  endfunction

  // Wait for an entry, check the head and pop it
  task automatic pop_entry(input acq_entry_t exp, input string what);
    int waited;
    waited = 0;
    while (acq_depth == '0 && waited < EntryTimeout) begin
      wait_cycles(1);
      waited++;
    end
    if (acq_depth == '0) begin
      $display("Timed out waiting for the acquisition entry for %s", what);
      errors++;
    end else begin
      compare_entry(acq_entry, exp, what);
      acq_rd = 1'b1;
      wait_cycles(1);
      acq_rd = 1'b0;
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic test_reset_idle();
    compare_bit(target_idle, 1'b1, "idle after reset");
    compare_bit(sda_dut, 1'b1, "sda_o after reset");
    compare_bit(tx_pop, 1'b0, "tx_pop_o after reset");
    compare_count(acq_depth, '0, "FIFO level after reset");
  endtask

  task automatic test_write_transfer();
    i2c_byte_t data [3];
    logic      ack;
    int        complete_before;
    complete_before = complete_count;
    foreach (data[i]) data[i] = i2c_byte_t'($urandom());
    bus_start();
    write_byte(address_byte(Addr0, 1'b0), ack);
    compare_bit(ack, 1'b1, "write address ACK");
    foreach (data[i]) begin
      write_byte(data[i], ack);
      compare_bit(ack, 1'b1, "write data ACK");
    end
    bus_stop();
    pop_entry(make_entry(AcqStart, address_byte(Addr0, 1'b0)), "write Start");
    foreach (data[i]) pop_entry(make_entry(AcqData, data[i]), "write data");
    pop_entry(make_entry(AcqStop, 8'h00), "write Stop");
    compare_count(acq_cnt_t'(complete_count - complete_before), 4'd1, "command complete pulses");
  endtask

  task automatic test_address_match();
    i2c_byte_t data;
    logic      ack;
    int        nack_before;
    int        complete_before;
    data = i2c_byte_t'($urandom());
    bus_start();
    write_byte(address_byte(AddrMask1Hit, 1'b0), ack);
    compare_bit(ack, 1'b1, "mask1 address ACK");
    write_byte(data, ack);
    compare_bit(ack, 1'b1, "mask1 data ACK");
    bus_stop();
    pop_entry(make_entry(AcqStart, address_byte(AddrMask1Hit, 1'b0)), "mask1 Start");
    pop_entry(make_entry(AcqData, data), "mask1 data");
    pop_entry(make_entry(AcqStop, 8'h00), "mask1 Stop");
    // A transfer for someone else must leave no trace
    nack_before     = nack_count;
    complete_before = complete_count;
    bus_start();
    write_byte(address_byte(AddrForeign, 1'b0), ack);
    compare_bit(ack, 1'b0, "foreign address ACK");
    bus_stop();
    compare_count(acq_depth, '0, "FIFO level after foreign transfer");
    compare_count(acq_cnt_t'(nack_count - nack_before), '0, "NACK events on foreign transfer");
    compare_count(acq_cnt_t'(complete_count - complete_before), '0, "foreign command complete");
  endtask

  task automatic test_read_transfer();
    i2c_byte_t first;
    i2c_byte_t second;
    i2c_byte_t got;
    logic      ack;
    int        pops_before;
    first  = i2c_byte_t'($urandom());
    second = i2c_byte_t'($urandom());
    tx_queue.push_back(first);
    tx_queue.push_back(second);
    pops_before = pop_count;
    bus_start();
    write_byte(address_byte(Addr0, 1'b1), ack);
    compare_bit(ack, 1'b1, "read address ACK");
    read_byte(1'b1, got);
    compare_byte(got, first, "first read byte");
    read_byte(1'b0, got);
    compare_byte(got, second, "second read byte");
    bus_stop();
    compare_count(acq_cnt_t'(pop_count - pops_before), 4'd2, "tx_pop_o pulses");
    // With the source empty the target sends all ones and pops nothing
    bus_start();
    write_byte(address_byte(Addr0, 1'b1), ack);
    compare_bit(ack, 1'b1, "empty source address ACK");
    read_byte(1'b0, got);
    compare_byte(got, 8'hFF, "byte from empty source");
    bus_stop();
    compare_count(acq_cnt_t'(pop_count - pops_before), 4'd2, "tx_pop_o pulses, empty source");
    pop_entry(make_entry(AcqStart, address_byte(Addr0, 1'b1)), "read Start");
    pop_entry(make_entry(AcqStop, 8'h00), "read Stop");
    pop_entry(make_entry(AcqStart, address_byte(Addr0, 1'b1)), "empty read Start");
    pop_entry(make_entry(AcqStop, 8'h00), "empty read Stop");
  endtask

  task automatic test_repeated_start();
    i2c_byte_t data;
    i2c_byte_t src;
    i2c_byte_t got;
    logic      ack;
    data = i2c_byte_t'($urandom());
    src  = i2c_byte_t'($urandom());
    tx_queue.push_back(src);
    bus_start();
    write_byte(address_byte(Addr0, 1'b0), ack);
    compare_bit(ack, 1'b1, "restart write address ACK");
    write_byte(data, ack);
    compare_bit(ack, 1'b1, "restart write data ACK");
    bus_restart();
    write_byte(address_byte(Addr0, 1'b1), ack);
    compare_bit(ack, 1'b1, "restart read address ACK");
    read_byte(1'b0, got);
    compare_byte(got, src, "byte after restart");
    bus_stop();
    pop_entry(make_entry(AcqStart, address_byte(Addr0, 1'b0)), "restart first Start");
    pop_entry(make_entry(AcqData, data), "restart data");
    pop_entry(make_entry(AcqRestart, address_byte(Addr0, 1'b1)), "restart entry");
    pop_entry(make_entry(AcqStop, 8'h00), "restart Stop");
  endtask

  // Bytes are accepted while free space stays above the reserve
  task automatic test_full_fifo();
    i2c_byte_t data [AcqDepth];
    logic      ack;
    logic      exp_ack;
    logic      nacked;
    int        free_model;
    int        accepted;
    int        nack_before;
    nack_before = nack_count;
    nacked      = 1'b0;
    accepted    = 0;
    bus_start();
    write_byte(address_byte(Addr0, 1'b0), ack);
    compare_bit(ack, 1'b1, "full test address ACK");
    free_model = int'(AcqDepth) - 1;
    foreach (data[i]) begin
      data[i] = i2c_byte_t'($urandom());
      write_byte(data[i], ack);
      exp_ack = !nacked && (free_model > int'(AcqReserve));
      compare_bit(ack, exp_ack, "full test data ACK");
      if (exp_ack) begin
        free_model--;
        accepted++;
      end else begin
        nacked = 1'b1;
      end
    end
    bus_stop();
    compare_count(acq_cnt_t'(nack_count - nack_before), acq_cnt_t'(nacked), "NACK events");
    compare_count(acq_depth, acq_cnt_t'(accepted + 2), "FIFO level when full");
    pop_entry(make_entry(AcqStart, address_byte(Addr0, 1'b0)), "full test Start");
    for (int i = 0; i < accepted; i++) begin
      pop_entry(make_entry(AcqData, data[i]), "full test data");
    end
    pop_entry(make_entry(AcqNackStop, 8'h00), "full test NACK Stop");
  endtask

  initial begin
    int waited;
    scl      = 1'b1;
    sda_host = 1'b1;
    acq_rd   = 1'b0;
    waited   = 0;
    void'($urandom(RandSeed));
    while (!rst_n && waited < ResetTimeout) begin
      wait_cycles(1);
      waited++;
    end
    if (!rst_n) begin
      $display("Reset was never released");
      errors++;
    end
    wait_cycles(2);
    test_reset_idle();
    test_write_transfer();
    test_address_match();
    test_read_transfer();
    test_repeated_start();
    test_full_fifo();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Ends a run that stops making progress
  initial begin
    #(WatchdogNs);
    $display("Simulation stopped by the watchdog timer");
    $display("Some tests failed");
    $finish;
  end

endmodule
